/* rtl/cpc_mem_pkg.sv */
package cpc_mem_pkg;

	//////////////////////////////
	// Memory geometry
	//////////////////////////////
	localparam int MEM_AW  = 12;  // Byte address width
	localparam int PAGE_AW = 8;   // Offset bits inside one page

	typedef logic [MEM_AW-1:0] mem_addr_t;
	typedef logic [7:0]        byte_t;

	//////////////////////////////
	// Download stream
	//////////////////////////////
	localparam byte_t IDX_ROM  = 8'd0;  // System ROM image
	localparam byte_t IDX_EXT  = 8'd3;  // Expansion ROM, page taken from extension
	localparam byte_t IDX_TAPE = 8'd4;  // Tape image

	// Fixed ROM pages, counted inside the ROM half
	localparam int SLOT_OS     = 0;
	localparam int SLOT_BASIC  = 1;
	localparam int SLOT_AMSDOS = 7;

	// Tape image starts at page 1 of the RAM half
	localparam mem_addr_t TAPE_BASE = mem_addr_t'(2 ** PAGE_AW);

endpackage

/* rtl/mem_port_if.sv */
`timescale 1ns/100ps

interface mem_port_if
	import cpc_mem_pkg::*;
();

	logic      req;     // Held with its fields until gnt
	logic      we;
	mem_addr_t addr;
	byte_t     wdata;
	logic      gnt;     // Single cycle, access done here
	byte_t     rdata;
	logic      rvalid;  // Cycle after a read grant

	modport requester (
		output req, we, addr, wdata,
		input  gnt, rdata, rvalid
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output gnt, rdata, rvalid
	);

endinterface

/* rtl/rom_loader.sv */
`timescale 1ns/100ps

module rom_loader
	import cpc_mem_pkg::*;
#(
	parameter int  MEM_AW    = cpc_mem_pkg::MEM_AW,
	parameter int  PAGE_AW   = cpc_mem_pkg::PAGE_AW,
	localparam int RP_W      = MEM_AW - 1 - PAGE_AW,
	localparam int ROM_PAGES = 2 ** RP_W
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 dl_active_i,
	input  byte_t                dl_index_i,
	input  logic                 dl_wr_i,
	input  mem_addr_t            dl_addr_i,
	input  byte_t                dl_data_i,
	input  logic [15:0]          dl_ext_i,
	mem_port_if.requester        mem,
	output logic [ROM_PAGES-1:0] rom_map_o,
	output mem_addr_t            tape_last_o,
	output logic                 tape_load_o
);

	typedef logic [RP_W-1:0] rom_page_t;

	logic                      active_q;        // dl_active_i one cycle back
	logic                      ext_ok_q;
	rom_page_t                 ext_page_q;
	logic                      tape_started_q;
	logic                      dl_start;
	logic [4:0]                hex_hi;
	logic [4:0]                hex_lo;
	logic                      ext_ok;
	rom_page_t                 ext_page;
	logic [MEM_AW-PAGE_AW-1:0] dl_page;
	logic [PAGE_AW-1:0]        dl_offset;
	logic                      map_ok;
	mem_addr_t                 map_addr;
	logic                      dl_tape;
	logic                      tape_wr;
	logic                      tape_first;

	// {valid, value} of one ASCII hex digit
	function automatic logic [4:0] hex_digit(input byte_t c);
		logic [4:0] d;
		d = 5'd0;
		if (c >= "0" && c <= "9")
			d = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			d = {1'b1, c[3:0] + 4'd9};
		return d;
	endfunction

	assign dl_start = dl_active_i & ~active_q;
	assign hex_hi   = hex_digit(dl_ext_i[15:8]);
	assign hex_lo   = hex_digit(dl_ext_i[7:0]);

	//////////////////////////////
	// Extension start page
	//////////////////////////////
	always_comb begin
		ext_ok   = ext_ok_q;
		ext_page = ext_page_q;
		if (dl_start && dl_index_i == IDX_EXT) begin
			ext_ok   = 1'b0;              // Bad extension drops the whole file
			ext_page = '0;
			if (dl_ext_i == "ZZ") begin
				ext_ok = 1'b1;
			end else if (hex_hi[4] && hex_lo[4]) begin
				ext_ok   = 1'b1;
				ext_page = rom_page_t'({hex_hi[3:0], hex_lo[3:0]});  // Wraps on page count
			end
		end
	end

	//////////////////////////////
	// Download address mapping
	//////////////////////////////
	always_comb begin
		dl_page   = dl_addr_i[MEM_AW-1:PAGE_AW];
		dl_offset = dl_addr_i[PAGE_AW-1:0];
		map_ok    = 1'b0;
		map_addr  = '0;
		dl_tape   = 1'b0;
		case (dl_index_i)
			IDX_ROM: begin
				map_ok = 1'b1;
				case (dl_page)
					0: map_addr = {1'b1, rom_page_t'(SLOT_OS), dl_offset};
					1: map_addr = {1'b1, rom_page_t'(SLOT_BASIC), dl_offset};
					2: map_addr = {1'b1, rom_page_t'(SLOT_AMSDOS), dl_offset};
					default: map_ok = 1'b0;
				endcase
			end
			IDX_EXT: begin
				map_ok   = ext_ok;
				map_addr = {1'b1, rom_page_t'(ext_page + dl_page[RP_W-1:0]), dl_offset};
			end
			IDX_TAPE: begin
				map_addr = TAPE_BASE + dl_addr_i;
				map_ok   = ~map_addr[MEM_AW-1];  // Tape must stay in the RAM half
				dl_tape  = 1'b1;
			end
			default: ;
		endcase
	end

	assign tape_wr    = dl_active_i & dl_wr_i & map_ok & dl_tape;
	assign tape_first = tape_wr & (~tape_started_q | dl_start);
	assign mem.we     = 1'b1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q       <= 1'b0;
			ext_ok_q       <= 1'b1;
			ext_page_q     <= '0;
			tape_started_q <= 1'b0;
			tape_load_o    <= 1'b0;
			tape_last_o    <= TAPE_BASE - 1'b1;  // Empty tape
			rom_map_o      <= '0;
			mem.req        <= 1'b0;
		end else begin
			active_q    <= dl_active_i;
			ext_ok_q    <= ext_ok;
			ext_page_q  <= ext_page;
			tape_load_o <= tape_first;
			mem.req     <= dl_active_i & dl_wr_i & map_ok;  // Granted next cycle
			if (tape_wr) begin
				tape_started_q <= 1'b1;
				if (tape_first || map_addr > tape_last_o)
					tape_last_o <= map_addr;
			end else if (dl_start) begin
				tape_started_q <= 1'b0;
			end
			if (mem.gnt && mem.addr[MEM_AW-1])
				rom_map_o[mem.addr[MEM_AW-2:PAGE_AW]] <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		mem.addr  <= map_addr;
		mem.wdata <= dl_data_i;
	end

endmodule

/* rtl/tape_fetch.sv */
`timescale 1ns/100ps

module tape_fetch
	import cpc_mem_pkg::*;
#(
	parameter int MEM_AW = cpc_mem_pkg::MEM_AW
) (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          dl_active_i,
	input  logic          tape_load_i,
	input  mem_addr_t     tape_last_i,
	input  logic          tape_req_i,
	output logic          tape_ack_o,
	output byte_t         tape_data_o,
	output logic          tape_end_o,
	mem_port_if.requester mem
);

	logic [MEM_AW-1:0] play_addr_q;
	logic              rd_wait_q;  // Granted, data due next cycle
	logic              start;

	// New toggle, nothing in flight and no download running
	assign start = (tape_req_i ^ tape_ack_o) & ~dl_active_i & ~tape_end_o
		& ~mem.req & ~rd_wait_q;

	assign mem.we    = 1'b0;
	assign mem.addr  = play_addr_q;
	assign mem.wdata = '0;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			play_addr_q <= TAPE_BASE;
			rd_wait_q   <= 1'b0;
			tape_ack_o  <= 1'b0;
			tape_end_o  <= 1'b0;
			mem.req     <= 1'b0;
		end else begin
			if (mem.gnt) begin
				mem.req   <= 1'b0;
				rd_wait_q <= 1'b1;
			end
			if (mem.rvalid) begin
				rd_wait_q   <= 1'b0;
				tape_ack_o  <= ~tape_ack_o;
				play_addr_q <= play_addr_q + 1'b1;
			end
			if (tape_load_i) begin
				play_addr_q <= TAPE_BASE;  // Rewind on new image
				tape_end_o  <= 1'b0;
			end else if (start) begin
				if (play_addr_q <= tape_last_i)
					mem.req <= 1'b1;
				else
					tape_end_o <= 1'b1;  // Past last byte, no ack
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (mem.rvalid)
			tape_data_o <= mem.rdata;
	end

endmodule

/* rtl/cpu_apb_port.sv */
`timescale 1ns/100ps

module cpu_apb_port
	import cpc_mem_pkg::*;
#(
	parameter int MEM_AW = cpc_mem_pkg::MEM_AW
) (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          psel_i,
	input  logic          penable_i,
	input  logic          pwrite_i,
	input  mem_addr_t     paddr_i,
	input  byte_t         pwdata_i,
	output byte_t         prdata_o,
	output logic          pready_o,
	mem_port_if.requester mem
);

	typedef enum logic [1:0] {ST_IDLE, ST_GNT, ST_DATA} state_t;

	state_t state_q;
	logic   pready_q;  // Write completion pulse
	logic   setup;

	assign setup    = psel_i & ~penable_i;
	assign pready_o = pready_q | (state_q == ST_DATA && mem.rvalid);
	assign prdata_o = mem.rdata;  // Valid with rvalid

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state_q  <= ST_IDLE;
			pready_q <= 1'b0;
			mem.req  <= 1'b0;
		end else begin
			pready_q <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (setup) begin
						if (pwrite_i && paddr_i[MEM_AW-1]) begin
							pready_q <= 1'b1;  // ROM half is read-only for the CPU
						end else begin
							mem.req <= 1'b1;
							state_q <= ST_GNT;
						end
					end
				end
				ST_GNT: begin
					if (mem.gnt) begin
						mem.req <= 1'b0;
						if (mem.we) begin
							pready_q <= 1'b1;
							state_q  <= ST_IDLE;
						end else begin
							state_q <= ST_DATA;
						end
					end
				end
				ST_DATA: begin
					if (mem.rvalid)
						state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// Request fields captured in the setup phase
	always_ff @(posedge clk_sys) begin
		if (state_q == ST_IDLE && setup) begin
			mem.we    <= pwrite_i;
			mem.addr  <= paddr_i;
			mem.wdata <= pwdata_i;
		end
	end

endmodule

/* rtl/arbitrated_ram.sv */
`timescale 1ns/100ps

module arbitrated_ram
	import cpc_mem_pkg::*;
#(
	parameter int MEM_AW = cpc_mem_pkg::MEM_AW
) (
	input  logic        clk_sys,
	input  logic        reset,
	mem_port_if.arbiter dl,
	mem_port_if.arbiter tape,
	mem_port_if.arbiter cpu
);

	localparam int DEPTH = 2 ** MEM_AW;

	byte_t     ram_q [DEPTH];
	byte_t     rdata_q;
	logic      any_req;
	logic      sel_we;
	mem_addr_t sel_addr;
	byte_t     sel_wdata;

	//////////////////////////////
	// Fixed priority grant
	//////////////////////////////
	assign dl.gnt   = dl.req;
	assign tape.gnt = tape.req & ~dl.req;
	assign cpu.gnt  = cpu.req & ~dl.req & ~tape.req;
	assign any_req  = dl.req | tape.req | cpu.req;

	always_comb begin
		sel_we    = cpu.we;
		sel_addr  = cpu.addr;
		sel_wdata = cpu.wdata;
		if (dl.req) begin
			sel_we    = dl.we;
			sel_addr  = dl.addr;
			sel_wdata = dl.wdata;
		end else if (tape.req) begin
			sel_we    = tape.we;
			sel_addr  = tape.addr;
			sel_wdata = tape.wdata;
		end
	end

	//////////////////////////////
	// Byte array
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (any_req) begin
			if (sel_we)
				ram_q[sel_addr] <= sel_wdata;
			rdata_q <= ram_q[sel_addr];
		end
	end

	assign dl.rdata   = rdata_q;  // Shared, qualified per port by rvalid
	assign tape.rdata = rdata_q;
	assign cpu.rdata  = rdata_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl.rvalid   <= 1'b0;
			tape.rvalid <= 1'b0;
			cpu.rvalid  <= 1'b0;
		end else begin
			dl.rvalid   <= dl.gnt & ~dl.we;
			tape.rvalid <= tape.gnt & ~tape.we;
			cpu.rvalid  <= cpu.gnt & ~cpu.we;
		end
	end

endmodule

/* rtl/cpc_loader_top.sv */
`timescale 1ns/100ps

module cpc_loader_top
	import cpc_mem_pkg::*;
#(
	parameter int  MEM_AW    = cpc_mem_pkg::MEM_AW,
	parameter int  PAGE_AW   = cpc_mem_pkg::PAGE_AW,
	localparam int ROM_PAGES = 2 ** (MEM_AW - 1 - PAGE_AW)
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	// Download stream
	input  logic                 dl_active_i,
	input  byte_t                dl_index_i,
	input  logic                 dl_wr_i,
	input  mem_addr_t            dl_addr_i,
	input  byte_t                dl_data_i,
	input  logic [15:0]          dl_ext_i,
	// CPU side, APB
	input  logic                 psel_i,
	input  logic                 penable_i,
	input  logic                 pwrite_i,
	input  mem_addr_t            paddr_i,
	input  byte_t                pwdata_i,
	output byte_t                prdata_o,
	output logic                 pready_o,
	// Tape player
	input  logic                 tape_req_i,
	output logic                 tape_ack_o,
	output byte_t                tape_data_o,
	output logic                 tape_end_o,
	output logic [ROM_PAGES-1:0] rom_map_o
);

	mem_addr_t tape_last;
	logic      tape_load;

	mem_port_if dl_bus ();
	mem_port_if tape_bus ();
	mem_port_if cpu_bus ();

	rom_loader #(.MEM_AW(MEM_AW), .PAGE_AW(PAGE_AW)) u_rom_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_ext_i    (dl_ext_i),
		.mem         (dl_bus.requester),
		.rom_map_o   (rom_map_o),
		.tape_last_o (tape_last),
		.tape_load_o (tape_load)
	);

	tape_fetch #(.MEM_AW(MEM_AW)) u_tape_fetch (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.tape_load_i (tape_load),
		.tape_last_i (tape_last),
		.tape_req_i  (tape_req_i),
		.tape_ack_o  (tape_ack_o),
		.tape_data_o (tape_data_o),
		.tape_end_o  (tape_end_o),
		.mem         (tape_bus.requester)
	);

	cpu_apb_port #(.MEM_AW(MEM_AW)) u_cpu_apb_port (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.mem       (cpu_bus.requester)
	);

	// Download first, then tape, then CPU
	arbitrated_ram #(.MEM_AW(MEM_AW)) u_arbitrated_ram (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl      (dl_bus.arbiter),
		.tape    (tape_bus.arbiter),
		.cpu     (cpu_bus.arbiter)
	);

endmodule

/* verif/cpc_properties.sv */
`timescale 1ns/100ps

module cpc_properties (
	input logic clk_sys,
	input logic reset,
	input logic psel_i,
	input logic penable_i,
	input logic pready_i,
	input logic tape_ack_i,
	input logic tape_end_i,
	input logic dl_gnt_i,
	input logic tape_gnt_i,
	input logic cpu_gnt_i
);

	// APB completion only inside an access phase
	assert property (@(posedge clk_sys) disable iff (reset)
		$rose(pready_i) |-> psel_i && penable_i)
		else $error("pready outside of an APB access phase");

	assert property (@(posedge clk_sys) disable iff (reset)
		tape_end_i |=> $stable(tape_ack_i))
		else $error("tape acknowledge toggled after end of tape");

	// Outputs cleared by the reset cycle
	assert property (@(posedge clk_sys) $fell(reset) |-> !tape_end_i && !tape_ack_i)
		else $error("tape outputs not cleared by reset");

	assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({dl_gnt_i, tape_gnt_i, cpu_gnt_i}))
		else $error("more than one grant in a cycle");

endmodule

/* verif/tb_checker.sv */
`timescale 1ns/100ps

module tb_checker
	import cpc_mem_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_active_i,
	input  byte_t       dl_index_i,
	input  logic        dl_wr_i,
	input  mem_addr_t   dl_addr_i,
	input  byte_t       dl_data_i,
	input  logic [15:0] dl_ext_i,
	input  logic        psel_i,
	input  logic        penable_i,
	input  logic        pwrite_i,
	input  mem_addr_t   paddr_i,
	input  byte_t       pwdata_i,
	input  byte_t       prdata_i,
	input  logic        pready_i,
	input  logic        tape_ack_i,
	input  byte_t       tape_data_i,
	input  logic        tape_end_i,
	input  logic [7:0]  rom_map_i,
	input  logic        map_chk_i,
	input  logic [7:0]  map_exp_i,
	output int          err_count_o
);

	localparam int ROM_BASE  = 2 ** (MEM_AW - 1);
	localparam int PAGE_SIZE = 2 ** PAGE_AW;
	localparam int ROM_PAGES = 2 ** (MEM_AW - 1 - PAGE_AW);

	byte_t      ref_mem [2 ** MEM_AW];  // Reference memory
	logic [7:0] ref_map;
	logic       act_q;
	logic       ext_ok;
	int         ext_page;
	logic       tape_new;
	int         tape_len;
	int         tape_idx;
	logic       ack_q;
	logic       end_q;

	// ASCII hex digit, -1 when not a digit
	function automatic int hex_val(input byte_t c);
		if (c >= "0" && c <= "9")
			return int'(c) - 48;
		if (c >= "A" && c <= "F")
			return int'(c) - 55;
		return -1;
	endfunction

	initial err_count_o = 0;

	always @(negedge clk_sys) begin : watch
		int a;
		int pg;
		int off;
		logic ok;
		if (reset) begin
			ref_map  = '0;
			act_q    = 1'b0;
			ext_ok   = 1'b1;
			ext_page = 0;
			tape_new = 1'b0;
			tape_len = 0;
			tape_idx = 0;
			ack_q    = 1'b0;
			end_q    = 1'b0;
		end else begin
			//////////////////////////////
			// Download model
			//////////////////////////////
			if (dl_active_i && !act_q) begin
				if (dl_index_i == IDX_EXT) begin
					if (dl_ext_i == "ZZ") begin
						ext_ok   = 1'b1;
						ext_page = 0;
					end else begin
						ext_ok   = hex_val(dl_ext_i[15:8]) >= 0 && hex_val(dl_ext_i[7:0]) >= 0;
						ext_page = hex_val(dl_ext_i[15:8]) * 16 + hex_val(dl_ext_i[7:0]);
					end
				end
				if (dl_index_i == IDX_TAPE)
					tape_new = 1'b1;
			end
			act_q = dl_active_i;
			if (dl_active_i && dl_wr_i) begin
				pg  = int'(dl_addr_i) / PAGE_SIZE;
				off = int'(dl_addr_i) % PAGE_SIZE;
				ok  = 1'b0;
				a   = 0;
				if (dl_index_i == IDX_ROM && pg < 3) begin
					ok = 1'b1;
					a  = ROM_BASE + off;
					a  = a + PAGE_SIZE * ((pg == 0) ? SLOT_OS : (pg == 1) ? SLOT_BASIC : SLOT_AMSDOS);
				end else if (dl_index_i == IDX_EXT && ext_ok) begin
					ok = 1'b1;
					a  = ROM_BASE + PAGE_SIZE * ((ext_page + pg) % ROM_PAGES) + off;
				end else if (dl_index_i == IDX_TAPE) begin
					a  = int'(TAPE_BASE) + int'(dl_addr_i);
					ok = a < ROM_BASE;
					if (ok && tape_new) begin  // New image rewinds the player
						tape_new = 1'b0;
						tape_len = 0;
						tape_idx = 0;
					end
					if (ok && int'(dl_addr_i) + 1 > tape_len)
						tape_len = int'(dl_addr_i) + 1;
				end
				if (ok) begin
					ref_mem[a] = dl_data_i;
					if (a >= ROM_BASE)
						ref_map[(a - ROM_BASE) / PAGE_SIZE] = 1'b1;
				end
			end

			// APB completion
			if (psel_i && penable_i && pready_i) begin
				if (pwrite_i) begin
					if (!paddr_i[MEM_AW-1])
						ref_mem[paddr_i] = pwdata_i;  // ROM half stays untouched
				end else if (prdata_i !== ref_mem[paddr_i]) begin
					$display("FAIL %0t: APB read at %03h gave %02h, expected %02h",
						$time, paddr_i, prdata_i, ref_mem[paddr_i]);
					err_count_o++;
				end
			end

			//////////////////////////////
			// Tape player
			//////////////////////////////
			if (tape_ack_i != ack_q) begin
				if (tape_idx >= tape_len) begin
					$display("FAIL %0t: tape acknowledge past the last byte", $time);
					err_count_o++;
				end else if (tape_data_i !== ref_mem[int'(TAPE_BASE) + tape_idx]) begin
					$display("FAIL %0t: tape byte %0d gave %02h, expected %02h", $time,
						tape_idx, tape_data_i, ref_mem[int'(TAPE_BASE) + tape_idx]);
					err_count_o++;
				end
				tape_idx++;
			end
			ack_q = tape_ack_i;
			if (tape_end_i && !end_q && tape_idx != tape_len) begin
				$display("FAIL %0t: tape end after %0d of %0d bytes", $time, tape_idx, tape_len);
				err_count_o++;
			end
			end_q = tape_end_i;

			if (map_chk_i && (rom_map_i !== map_exp_i || rom_map_i !== ref_map)) begin
				$display("FAIL %0t: ROM map %02h, expected %02h, model %02h",
					$time, rom_map_i, map_exp_i, ref_map);
				err_count_o++;
			end
		end
	end

endmodule

/* verif/tb_top.sv */
`timescale 1ns/100ps

module tb_top
	import cpc_mem_pkg::*;
;

	typedef enum logic [3:0] {
		OP_ROM, OP_EXT, OP_TAPE, OP_WR, OP_RD, OP_TREQ, OP_TEND, OP_MIX, OP_MAP
	} op_t;

	typedef struct packed {
		op_t         op;
		mem_addr_t   addr;
		logic [7:0]  count;
		logic [15:0] ext;
		logic [7:0]  exp;  // ROM map where fixed
	} row_t;

	localparam int NROWS = 27;

	logic        clk_sys;
	logic        reset;
	logic        dl_active_i;
	byte_t       dl_index_i;
	logic        dl_wr_i;
	mem_addr_t   dl_addr_i;
	byte_t       dl_data_i;
	logic [15:0] dl_ext_i;
	logic        psel_i;
	logic        penable_i;
	logic        pwrite_i;
	mem_addr_t   paddr_i;
	byte_t       pwdata_i;
	byte_t       prdata_o;
	logic        pready_o;
	logic        tape_req_i;
	logic        tape_ack_o;
	byte_t       tape_data_o;
	logic        tape_end_o;
	logic [7:0]  rom_map_o;
	logic        map_chk;
	logic [7:0]  map_exp;
	int          chk_errs;
	int          tb_errs;
	integer      seed;
	row_t        rows [NROWS];

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	cpc_loader_top #(.MEM_AW(MEM_AW), .PAGE_AW(PAGE_AW)) uut (.*);

	tb_checker scoreboard (
		.clk_sys(clk_sys), .reset(reset),
		.dl_active_i(dl_active_i), .dl_index_i(dl_index_i), .dl_wr_i(dl_wr_i),
		.dl_addr_i(dl_addr_i), .dl_data_i(dl_data_i), .dl_ext_i(dl_ext_i),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i), .paddr_i(paddr_i),
		.pwdata_i(pwdata_i), .prdata_i(prdata_o), .pready_i(pready_o),
		.tape_ack_i(tape_ack_o), .tape_data_i(tape_data_o), .tape_end_i(tape_end_o),
		.rom_map_i(rom_map_o), .map_chk_i(map_chk), .map_exp_i(map_exp),
		.err_count_o(chk_errs)
	);

	bind cpc_loader_top cpc_properties props (
		.clk_sys(clk_sys), .reset(reset), .psel_i(psel_i), .penable_i(penable_i),
		.pready_i(pready_o), .tape_ack_i(tape_ack_o), .tape_end_i(tape_end_o),
		.dl_gnt_i(dl_bus.gnt), .tape_gnt_i(tape_bus.gnt), .cpu_gnt_i(cpu_bus.gnt)
	);

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////
	task automatic download(input byte_t idx, input logic [15:0] ext,
		input mem_addr_t base, input int count);
		int i;
		@(posedge clk_sys);
		dl_active_i <= 1'b1;
		dl_index_i  <= idx;
		dl_ext_i    <= ext;
		for (i = 0; i < count; i++) begin
			@(posedge clk_sys);
			dl_wr_i   <= 1'b1;
			dl_addr_i <= base + mem_addr_t'(i);
			dl_data_i <= byte_t'($random(seed));
		end
		@(posedge clk_sys);
		dl_wr_i     <= 1'b0;
		dl_active_i <= 1'b0;
		repeat (4) @(posedge clk_sys);  // Last write lands two cycles after its pulse
	endtask

	task automatic apb_xfer(input logic wr, input mem_addr_t addr);
		int n;
		n = 0;
		@(posedge clk_sys);
		psel_i    <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i  <= wr;
		paddr_i   <= addr;
		pwdata_i  <= byte_t'($random(seed));
		@(posedge clk_sys);
		penable_i <= 1'b1;
		@(negedge clk_sys);
		while (!pready_o && n < 64) begin
			@(negedge clk_sys);
			n++;
		end
		if (!pready_o) begin
			$display("APB transfer at %03h never completed", addr);
			tb_errs++;
		end
		@(posedge clk_sys);
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
	endtask

	task automatic tape_step();
		int n;
		n = 0;
		@(posedge clk_sys);
		tape_req_i <= ~tape_req_i;
		@(negedge clk_sys);
		while (tape_ack_o != tape_req_i && n < 64) begin
			@(negedge clk_sys);
			n++;
		end
		if (tape_ack_o != tape_req_i) begin
			$display("Tape request got no acknowledge");
			tb_errs++;
		end
	endtask

	task automatic tape_finish();
		int n;
		n = 0;
		@(posedge clk_sys);
		tape_req_i <= ~tape_req_i;
		@(negedge clk_sys);
		while (!tape_end_o && n < 64) begin
			@(negedge clk_sys);
			n++;
		end
		if (!tape_end_o) begin
			$display("Tape end flag did not rise after the last byte");
			tb_errs++;
		end
		repeat (4) @(posedge clk_sys);
		tape_req_i <= tape_ack_o;  // Drop the refused request
	endtask

	// Tape fetch and APB read started together
	task automatic mix_step(input mem_addr_t addr);
		int   n;
		logic apb_done;
		logic ack_done;
		n        = 0;
		apb_done = 1'b0;
		ack_done = 1'b0;
		@(posedge clk_sys);
		tape_req_i <= ~tape_req_i;
		psel_i     <= 1'b1;
		penable_i  <= 1'b0;
		pwrite_i   <= 1'b0;
		paddr_i    <= addr;
		@(posedge clk_sys);
		penable_i <= 1'b1;
		while (!(apb_done && ack_done) && n < 64) begin
			@(negedge clk_sys);
			n++;
			if (psel_i && penable_i && pready_o)
				apb_done = 1'b1;
			if (tape_ack_o == tape_req_i)
				ack_done = 1'b1;
			if (apb_done && psel_i) begin
				@(posedge clk_sys);
				psel_i    <= 1'b0;
				penable_i <= 1'b0;
			end
		end
		if (!(apb_done && ack_done)) begin
			$display("Interleaved APB read and tape fetch did not both complete");
			tb_errs++;
			@(posedge clk_sys);
			psel_i    <= 1'b0;
			penable_i <= 1'b0;
		end
	endtask

	task automatic check_map(input logic [7:0] exp);
		@(posedge clk_sys);
		map_chk <= 1'b1;
		map_exp <= exp;
		@(posedge clk_sys);
		map_chk <= 1'b0;
	endtask

	//////////////////////////////
	// Stimulus table
	//////////////////////////////
	initial begin
		rows[0]  = '{OP_ROM,  12'h000, 8'd4, "  ", 8'h00};
		rows[1]  = '{OP_ROM,  12'h100, 8'd4, "  ", 8'h00};
		rows[2]  = '{OP_ROM,  12'h200, 8'd4, "  ", 8'h00};
		rows[3]  = '{OP_ROM,  12'h300, 8'd4, "  ", 8'h00};  // Page 3 is dropped
		rows[4]  = '{OP_MAP,  12'h000, 8'd0, "  ", 8'h83};
		rows[5]  = '{OP_RD,   12'h800, 8'd4, "  ", 8'h00};
		rows[6]  = '{OP_RD,   12'h900, 8'd4, "  ", 8'h00};
		rows[7]  = '{OP_RD,   12'hF00, 8'd4, "  ", 8'h00};
		rows[8]  = '{OP_EXT,  12'h000, 8'd4, "05", 8'h00};
		rows[9]  = '{OP_EXT,  12'h100, 8'd4, "05", 8'h00};
		rows[10] = '{OP_MAP,  12'h000, 8'd0, "  ", 8'hE3};
		rows[11] = '{OP_RD,   12'hD00, 8'd4, "  ", 8'h00};
		rows[12] = '{OP_RD,   12'hE00, 8'd4, "  ", 8'h00};
		rows[13] = '{OP_EXT,  12'h200, 8'd4, "Q1", 8'h00};  // Bad extension, no page written
		rows[14] = '{OP_MAP,  12'h000, 8'd0, "  ", 8'hE3};
		rows[15] = '{OP_RD,   12'hF00, 8'd4, "  ", 8'h00};
		rows[16] = '{OP_WR,   12'h300, 8'd4, "  ", 8'h00};
		rows[17] = '{OP_RD,   12'h300, 8'd4, "  ", 8'h00};
		rows[18] = '{OP_WR,   12'h800, 8'd2, "  ", 8'h00};
		rows[19] = '{OP_RD,   12'h800, 8'd4, "  ", 8'h00};
		rows[20] = '{OP_TAPE, 12'h000, 8'd6, "  ", 8'h00};
		rows[21] = '{OP_TREQ, 12'h000, 8'd6, "  ", 8'h00};
		rows[22] = '{OP_TEND, 12'h000, 8'd1, "  ", 8'h00};
		rows[23] = '{OP_TAPE, 12'h000, 8'd4, "  ", 8'h00};
		rows[24] = '{OP_MIX,  12'h300, 8'd4, "  ", 8'h00};
		rows[25] = '{OP_RD,   12'h100, 8'd4, "  ", 8'h00};
		rows[26] = '{OP_TEND, 12'h000, 8'd1, "  ", 8'h00};
	end

	initial begin : watchdog
		#(NROWS * 64 * 20);
		$display("Timeout, the test did not finish in time");
		$display("Verification failed");
		$finish;
	end

	initial begin : run
		int r;
		int i;
		seed        = 32'h39e0bdd3;
		tb_errs     = 0;
		reset       = 1'b1;
		dl_active_i = 1'b0;
		dl_index_i  = '0;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		dl_ext_i    = '0;
		psel_i      = 1'b0;
		penable_i   = 1'b0;
		pwrite_i    = 1'b0;
		paddr_i     = '0;
		pwdata_i    = '0;
		tape_req_i  = 1'b0;
		map_chk     = 1'b0;
		map_exp     = '0;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		for (r = 0; r < NROWS; r++) begin
			case (rows[r].op)
				OP_ROM:  download(IDX_ROM, rows[r].ext, rows[r].addr, int'(rows[r].count));
				OP_EXT:  download(IDX_EXT, rows[r].ext, rows[r].addr, int'(rows[r].count));
				OP_TAPE: download(IDX_TAPE, rows[r].ext, rows[r].addr, int'(rows[r].count));
				OP_MAP:  check_map(rows[r].exp);
				OP_TEND: tape_finish();
				default: begin
					for (i = 0; i < int'(rows[r].count); i++) begin
						if (rows[r].op == OP_WR)
							apb_xfer(1'b1, rows[r].addr + mem_addr_t'(i));
						else if (rows[r].op == OP_RD)
							apb_xfer(1'b0, rows[r].addr + mem_addr_t'(i));
						else if (rows[r].op == OP_TREQ)
							tape_step();
						else
							mix_step(rows[r].addr + mem_addr_t'(i));
					end
				end
			endcase
		end
		repeat (4) @(posedge clk_sys);
		$display("Errors: checker %0d, testbench %0d", chk_errs, tb_errs);
		if (chk_errs == 0 && tb_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* sources.f */
rtl/cpc_mem_pkg.sv
rtl/mem_port_if.sv
rtl/rom_loader.sv
rtl/tape_fetch.sv
rtl/cpu_apb_port.sv
rtl/arbitrated_ram.sv
rtl/cpc_loader_top.sv
verif/cpc_properties.sv
verif/tb_checker.sv
verif/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line appears
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
	-Mdir obj_dir -f sources.f || { echo "Build failed"; exit 1; }

OUT=$(./obj_dir/Vtb_top)
echo "$OUT"
echo "$OUT" | grep -qx "Verification passed" && exit 0 || exit 1
